// ==== mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0]    resetPc = 32'h0000_3000;
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;
    localparam logic [1:0]              tuseNone = 2'd3; // Source never read

    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } funct_t;

    typedef enum logic [2:0] {aluAdd, aluSub, aluOr, aluSlt, aluLui} aluOp_t;
    typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSel_t;
    typedef enum logic [2:0] {fwdNone, fwdELink, fwdMAlu, fwdMLink, fwdWResult} fwdSrc_t;

    typedef struct packed {
        aluOp_t                  aluOp;
        logic                    immSel;   // Operand B from immediate
        logic                    signExt;
        logic                    memWrite;
        logic                    regWrite; // Only set for nonzero dest
        wbSel_t                  wbSel;
        logic [regAddrWidth-1:0] dest;
        logic [1:0]              rsTuse;
        logic [1:0]              rtTuse;
        logic [1:0]              tNew;     // Cycles to result, counted in E
    } ctrl_t;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        ctrl_t                   ctrl;
        logic [regAddrWidth-1:0] rsAddr;
        logic [regAddrWidth-1:0] rtAddr;
        logic [dataWidth-1:0]    rsVal;
        logic [dataWidth-1:0]    rtVal;
        logic [dataWidth-1:0]    imm;
    } deReg_t;

    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        ctrl_t                   ctrl;
        logic [dataWidth-1:0]    aluRes;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] rtAddr;
    } emReg_t;

    typedef struct packed {
        logic [dataWidth-1:0] pc;
        ctrl_t                ctrl;
        logic [dataWidth-1:0] aluRes;
        logic [dataWidth-1:0] loadData;
    } mwReg_t;

    typedef struct packed {
        logic [regAddrWidth-1:0] dest;
        logic                    regWrite;
        wbSel_t                  wbSel;
        logic [1:0]              tNew;
    } hazardInfo_t;

    // Shared operand mux for every forwarding point
    function automatic logic [dataWidth-1:0] fwdMux(
        input fwdSrc_t              sel,
        input logic [dataWidth-1:0] base,
        input logic [dataWidth-1:0] eLink,
        input logic [dataWidth-1:0] mAlu,
        input logic [dataWidth-1:0] mLink,
        input logic [dataWidth-1:0] wResult
    );
        case (sel)
            fwdELink:   fwdMux = eLink;
            fwdMAlu:    fwdMux = mAlu;
            fwdMLink:   fwdMux = mLink;
            fwdWResult: fwdMux = wResult;
            default:    fwdMux = base;
        endcase
    endfunction

endpackage

// ==== fetchUnit.sv ====
`timescale 1ns/10ps

module fetchUnit (
    input  logic        clk,
    input  logic        arstN,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] pc
);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= mipsPkg::resetPc;
        end else if (!stall) begin          // Stall wins over a redirect
            if (branchTaken) begin
                pc <= branchTarget;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

// ==== regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [1:31]; // Register 0 is not stored

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Same-cycle write is visible to the decode read
    always_comb begin
        rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
        rtData = (rtAddr == '0) ? '0 : regs[rtAddr];
        if (writeEn && writeAddr != '0 && writeAddr == rsAddr) rsData = writeData;
        if (writeEn && writeAddr != '0 && writeAddr == rtAddr) rtData = writeData;
    end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stall,
    input  logic [31:0]           fetchPc,
    input  logic [31:0]           instr,
    input  logic [31:0]           rsData,
    input  logic [31:0]           rtData,
    input  mipsPkg::fwdSrc_t      fwdRs,
    input  mipsPkg::fwdSrc_t      fwdRt,
    input  logic [31:0]           eLink,
    input  logic [31:0]           mAlu,
    input  logic [31:0]           mLink,
    input  logic [31:0]           wResult,
    output logic [4:0]            rsAddr,
    output logic [4:0]            rtAddr,
    output logic                  branchTaken,
    output logic [31:0]           branchTarget,
    output mipsPkg::hazardInfo_t  dInfo,
    output logic [3:0]            dTuse,
    output mipsPkg::deReg_t       deNext
);

    logic [31:0]      fdPc;
    logic [31:0]      fdInstr;
    mipsPkg::opcode_t op;
    mipsPkg::funct_t  fn;
    mipsPkg::ctrl_t   ctrl;
    logic [31:0]      rsVal;
    logic [31:0]      rtVal;
    logic [31:0]      imm;
    logic [31:0]      pcPlus4;

    ////////////////////////////////////////////////////////////////////////////
    // F/D register

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fdPc    <= '0;
            fdInstr <= '0;                  // All-zero word decodes as nop
        end else if (!stall) begin
            fdPc    <= fetchPc;
            fdInstr <= instr;
        end
    end

    assign op     = mipsPkg::opcode_t'(fdInstr[31:26]);
    assign fn     = mipsPkg::funct_t'(fdInstr[5:0]);
    assign rsAddr = fdInstr[25:21];
    assign rtAddr = fdInstr[20:16];

    ////////////////////////////////////////////////////////////////////////////
    // Control decode with Tuse and Tnew

    always_comb begin
        ctrl        = '0;
        ctrl.rsTuse = mipsPkg::tuseNone;
        ctrl.rtTuse = mipsPkg::tuseNone;
        case (op)
            mipsPkg::opSpecial: begin
                ctrl.regWrite = 1'b1;
                ctrl.dest     = fdInstr[15:11];
                ctrl.rsTuse   = 2'd1;
                ctrl.rtTuse   = 2'd1;
                ctrl.tNew     = 2'd1;
                case (fn)
                    mipsPkg::fnAddu: ctrl.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSubu: ctrl.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnOr:   ctrl.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnSlt:  ctrl.aluOp = mipsPkg::aluSlt;
                    default:         ctrl.regWrite = 1'b0; // Includes sll nop
                endcase
            end
            mipsPkg::opOri, mipsPkg::opLui, mipsPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.dest     = fdInstr[20:16];
                ctrl.immSel   = 1'b1;
                ctrl.rsTuse   = (op == mipsPkg::opLui) ? mipsPkg::tuseNone : 2'd1;
                ctrl.tNew     = (op == mipsPkg::opLw) ? 2'd2 : 2'd1;
                ctrl.signExt  = (op == mipsPkg::opLw);
                ctrl.wbSel    = (op == mipsPkg::opLw) ? mipsPkg::wbMem : mipsPkg::wbAlu;
                ctrl.aluOp    = (op == mipsPkg::opOri) ? mipsPkg::aluOr :
                                (op == mipsPkg::opLui) ? mipsPkg::aluLui : mipsPkg::aluAdd;
            end
            mipsPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.immSel   = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.rsTuse   = 2'd1;
                ctrl.rtTuse   = 2'd2;       // Store data needed in M
            end
            mipsPkg::opBeq: begin
                ctrl.rsTuse = 2'd0;
                ctrl.rtTuse = 2'd0;
            end
            mipsPkg::opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.dest     = mipsPkg::linkReg;
                ctrl.wbSel    = mipsPkg::wbLink;
            end
            default: ;
        endcase
        if (ctrl.dest == '0) ctrl.regWrite = 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding, compare and next PC

    assign rsVal   = mipsPkg::fwdMux(fwdRs, rsData, eLink, mAlu, mLink, wResult);
    assign rtVal   = mipsPkg::fwdMux(fwdRt, rtData, eLink, mAlu, mLink, wResult);
    assign imm     = ctrl.signExt ? {{16{fdInstr[15]}}, fdInstr[15:0]} : {16'b0, fdInstr[15:0]};
    assign pcPlus4 = fdPc + 32'd4;

    assign branchTaken  = (op == mipsPkg::opJal) || (op == mipsPkg::opBeq && rsVal == rtVal);
    assign branchTarget = (op == mipsPkg::opJal) ? {pcPlus4[31:28], fdInstr[25:0], 2'b00}
                        : pcPlus4 + {{14{fdInstr[15]}}, fdInstr[15:0], 2'b00};

    assign dTuse = {ctrl.rtTuse, ctrl.rsTuse};
    assign dInfo = '{dest: ctrl.dest, regWrite: ctrl.regWrite, wbSel: ctrl.wbSel,
                     tNew: ctrl.tNew};
    assign deNext = '{pc: fdPc, ctrl: ctrl, rsAddr: rsAddr, rtAddr: rtAddr,
                      rsVal: rsVal, rtVal: rtVal, imm: imm};

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
    input  logic [4:0]           dRsAddr,
    input  logic [4:0]           dRtAddr,
    input  logic [3:0]           dTuse,
    input  mipsPkg::hazardInfo_t eInfo,
    input  mipsPkg::hazardInfo_t mInfo,
    input  mipsPkg::hazardInfo_t wInfo,
    input  logic [4:0]           eRsAddr,
    input  logic [4:0]           eRtAddr,
    input  logic [4:0]           mRtAddr,
    output logic                 stall,
    output mipsPkg::fwdSrc_t     fwdDRs,
    output mipsPkg::fwdSrc_t     fwdDRt,
    output mipsPkg::fwdSrc_t     fwdERs,
    output mipsPkg::fwdSrc_t     fwdERt,
    output mipsPkg::fwdSrc_t     fwdMRt
);

    // Value not ready by the cycle the D instruction needs it
    function automatic logic late(input logic [4:0] addr, input logic [1:0] tUse);
        late = (addr != '0) &&
               ((eInfo.regWrite && eInfo.dest == addr && eInfo.tNew > tUse) ||
                (mInfo.regWrite && mInfo.dest == addr && mInfo.tNew > tUse));
    endfunction

    // Nearest producer wins; not ready yet means leave the old value
    function automatic mipsPkg::fwdSrc_t pickSrc(input logic [4:0] addr,
                                                 input logic fromE, input logic fromM);
        pickSrc = mipsPkg::fwdNone;
        if (addr == '0) begin
            pickSrc = mipsPkg::fwdNone;
        end else if (fromE && eInfo.regWrite && eInfo.dest == addr) begin
            if (eInfo.tNew == 2'd0 && eInfo.wbSel == mipsPkg::wbLink) pickSrc = mipsPkg::fwdELink;
        end else if (fromM && mInfo.regWrite && mInfo.dest == addr) begin
            if (mInfo.tNew == 2'd0) begin
                pickSrc = (mInfo.wbSel == mipsPkg::wbLink) ? mipsPkg::fwdMLink
                                                           : mipsPkg::fwdMAlu;
            end
        end else if (wInfo.regWrite && wInfo.dest == addr) begin
            pickSrc = mipsPkg::fwdWResult;
        end
    endfunction

    always_comb begin
        stall  = late(dRsAddr, dTuse[1:0]) || late(dRtAddr, dTuse[3:2]);

        fwdDRs = pickSrc(dRsAddr, 1'b1, 1'b1);
        fwdDRt = pickSrc(dRtAddr, 1'b1, 1'b1);
        fwdERs = pickSrc(eRsAddr, 1'b0, 1'b1);   // Producers in M and W
        fwdERt = pickSrc(eRtAddr, 1'b0, 1'b1);
        fwdMRt = pickSrc(mRtAddr, 1'b0, 1'b0);   // Only W is behind M
    end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  mipsPkg::deReg_t      deNext,
    input  mipsPkg::fwdSrc_t     fwdRs,
    input  mipsPkg::fwdSrc_t     fwdRt,
    input  logic [31:0]          mAlu,
    input  logic [31:0]          mLink,
    input  logic [31:0]          wResult,
    output mipsPkg::hazardInfo_t eInfo,
    output logic [31:0]          eLink,
    output mipsPkg::emReg_t      emNext,
    output logic [4:0]           eRsAddr,
    output logic [4:0]           eRtAddr
);

    mipsPkg::deReg_t deReg;
    logic [31:0]     opA;
    logic [31:0]     rtFwd;
    logic [31:0]     opB;
    logic [31:0]     aluRes;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            deReg <= '0;
        end else begin
            deReg <= stall ? '0 : deNext;   // Bubble while D is held
        end
    end

    assign eRsAddr = deReg.rsAddr;
    assign eRtAddr = deReg.rtAddr;
    assign eLink   = deReg.pc + 32'd8;

    assign opA   = mipsPkg::fwdMux(fwdRs, deReg.rsVal, '0, mAlu, mLink, wResult);
    assign rtFwd = mipsPkg::fwdMux(fwdRt, deReg.rtVal, '0, mAlu, mLink, wResult);
    assign opB   = deReg.ctrl.immSel ? deReg.imm : rtFwd;

    always_comb begin
        case (deReg.ctrl.aluOp)
            mipsPkg::aluSub: aluRes = opA - opB;
            mipsPkg::aluOr:  aluRes = opA | opB;
            mipsPkg::aluSlt: aluRes = {31'b0, $signed(opA) < $signed(opB)};
            mipsPkg::aluLui: aluRes = {opB[15:0], 16'b0};
            default:         aluRes = opA + opB;
        endcase
    end

    assign eInfo  = '{dest: deReg.ctrl.dest, regWrite: deReg.ctrl.regWrite,
                      wbSel: deReg.ctrl.wbSel, tNew: deReg.ctrl.tNew};
    assign emNext = '{pc: deReg.pc, ctrl: deReg.ctrl, aluRes: aluRes,
                      storeData: rtFwd, rtAddr: deReg.rtAddr};

endmodule

// ==== memWriteback.sv ====
`timescale 1ns/10ps

module memWriteback (
    input  logic                 clk,
    input  logic                 arstN,
    input  mipsPkg::emReg_t      emNext,
    input  mipsPkg::fwdSrc_t     fwdRt,
    input  logic [31:0]          dataRdata,
    output logic [31:0]          dataAddr,
    output logic [31:0]          dataWdata,
    output logic                 dataWe,
    output mipsPkg::hazardInfo_t mInfo,
    output mipsPkg::hazardInfo_t wInfo,
    output logic [31:0]          mAlu,
    output logic [31:0]          mLink,
    output logic [31:0]          wResult,
    output logic [4:0]           mRtAddr,
    output logic                 grfWe,
    output logic [4:0]           grfAddr,
    output logic [31:0]          wbPc
);

    mipsPkg::emReg_t emReg;
    mipsPkg::mwReg_t mwReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            emReg <= '0;
            mwReg <= '0;
        end else begin
            emReg <= emNext;
            mwReg <= '{pc: emReg.pc, ctrl: emReg.ctrl, aluRes: emReg.aluRes,
                       loadData: dataRdata};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory stage

    assign mRtAddr   = emReg.rtAddr;
    assign dataAddr  = emReg.aluRes;
    assign dataWdata = mipsPkg::fwdMux(fwdRt, emReg.storeData, '0, '0, '0, wResult);
    assign dataWe    = emReg.ctrl.memWrite;
    assign mAlu      = emReg.aluRes;
    assign mLink     = emReg.pc + 32'd8;
    assign mInfo     = '{dest: emReg.ctrl.dest, regWrite: emReg.ctrl.regWrite,
                         wbSel: emReg.ctrl.wbSel,
                         tNew: (emReg.ctrl.tNew == 2'd0) ? 2'd0 : emReg.ctrl.tNew - 2'd1};

    ////////////////////////////////////////////////////////////////////////////
    // Writeback stage

    always_comb begin
        case (mwReg.ctrl.wbSel)
            mipsPkg::wbMem:  wResult = mwReg.loadData;
            mipsPkg::wbLink: wResult = mwReg.pc + 32'd8;
            default:         wResult = mwReg.aluRes;
        endcase
    end

    assign grfWe   = mwReg.ctrl.regWrite;
    assign grfAddr = mwReg.ctrl.dest;
    assign wbPc    = mwReg.pc;
    assign wInfo   = '{dest: mwReg.ctrl.dest, regWrite: mwReg.ctrl.regWrite,
                       wbSel: mwReg.ctrl.wbSel, tNew: 2'd0};

endmodule

// ==== mipsCore.sv ====
`timescale 1ns/10ps

module mipsCore (
    input  logic        clk,
    input  logic        arstN,
    output logic [31:0] instAddr,
    input  logic [31:0] instRdata,
    output logic [31:0] dataAddr,
    output logic [31:0] dataWdata,
    output logic        dataWe,
    input  logic [31:0] dataRdata,
    output logic        grfWe,
    output logic [4:0]  grfAddr,
    output logic [31:0] grfWdata,
    output logic [31:0] wbPc
);

    logic                 stall;
    logic                 branchTaken;
    logic [31:0]          branchTarget;
    logic [4:0]           rsAddr;
    logic [4:0]           rtAddr;
    logic [31:0]          rsData;
    logic [31:0]          rtData;
    logic [3:0]           dTuse;
    logic [31:0]          eLink;          // Link value of jal in E
    logic [31:0]          mAlu;
    logic [31:0]          mLink;
    logic [4:0]           eRsAddr;
    logic [4:0]           eRtAddr;
    logic [4:0]           mRtAddr;
    mipsPkg::hazardInfo_t dInfo;
    mipsPkg::hazardInfo_t eInfo;
    mipsPkg::hazardInfo_t mInfo;
    mipsPkg::hazardInfo_t wInfo;
    mipsPkg::deReg_t      deNext;
    mipsPkg::emReg_t      emNext;
    mipsPkg::fwdSrc_t     fwdDRs;
    mipsPkg::fwdSrc_t     fwdDRt;
    mipsPkg::fwdSrc_t     fwdERs;
    mipsPkg::fwdSrc_t     fwdERt;
    mipsPkg::fwdSrc_t     fwdMRt;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch and decode

    fetchUnit fetchUnit_inst (
        .clk(clk), .arstN(arstN), .stall(stall),
        .branchTaken(branchTaken), .branchTarget(branchTarget), .pc(instAddr)
    );

    regFile regFile_inst (
        .clk(clk), .arstN(arstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
        .writeEn(grfWe), .writeAddr(grfAddr), .writeData(grfWdata),
        .rsData(rsData), .rtData(rtData)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall),
        .fetchPc(instAddr), .instr(instRdata), .rsData(rsData), .rtData(rtData),
        .fwdRs(fwdDRs), .fwdRt(fwdDRt),
        .eLink(eLink), .mAlu(mAlu), .mLink(mLink), .wResult(grfWdata),
        .rsAddr(rsAddr), .rtAddr(rtAddr),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .dInfo(dInfo), .dTuse(dTuse), .deNext(deNext)
    );

    hazardUnit hazardUnit_inst (
        .dRsAddr(rsAddr), .dRtAddr(rtAddr), .dTuse(dTuse),
        .eInfo(eInfo), .mInfo(mInfo), .wInfo(wInfo),
        .eRsAddr(eRsAddr), .eRtAddr(eRtAddr), .mRtAddr(mRtAddr),
        .stall(stall), .fwdDRs(fwdDRs), .fwdDRt(fwdDRt),
        .fwdERs(fwdERs), .fwdERt(fwdERt), .fwdMRt(fwdMRt)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute, memory and writeback

    executeStage executeStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .deNext(deNext),
        .fwdRs(fwdERs), .fwdRt(fwdERt),
        .mAlu(mAlu), .mLink(mLink), .wResult(grfWdata),
        .eInfo(eInfo), .eLink(eLink), .emNext(emNext),
        .eRsAddr(eRsAddr), .eRtAddr(eRtAddr)
    );

    memWriteback memWriteback_inst (
        .clk(clk), .arstN(arstN), .emNext(emNext), .fwdRt(fwdMRt),
        .dataRdata(dataRdata), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataWe(dataWe), .mInfo(mInfo), .wInfo(wInfo),
        .mAlu(mAlu), .mLink(mLink), .wResult(grfWdata), .mRtAddr(mRtAddr),
        .grfWe(grfWe), .grfAddr(grfAddr), .wbPc(wbPc)
    );

endmodule

// ==== mipsCore_properties.sv ====
`timescale 1ns/10ps

module mipsCoreProperties (
    input logic        clk,
    input logic        arstN,
    input logic [31:0] instAddr,
    input logic [31:0] dataAddr,
    input logic        dataWe,
    input logic        grfWe,
    input logic [4:0]  grfAddr
);

    noZeroWrite: assert property (@(posedge clk) disable iff (!arstN) grfWe |-> grfAddr != 5'd0)
        else $error("grfWe pulsed for register 0");

    alignedStore: assert property (@(posedge clk) disable iff (!arstN)
                                   dataWe |-> dataAddr[1:0] == 2'b00)
        else $error("store address %h is not word aligned", dataAddr);

    alignedFetch: assert property (@(posedge clk) disable iff (!arstN) instAddr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", instAddr);

    // Nothing has reached M or W yet
    quietAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !grfWe && !dataWe)
        else $error("strobe active in the first cycle after reset");

endmodule

bind mipsCore mipsCoreProperties mipsCoreProperties_inst (
    .clk(clk), .arstN(arstN), .instAddr(instAddr), .dataAddr(dataAddr),
    .dataWe(dataWe), .grfWe(grfWe), .grfAddr(grfAddr)
);

// ==== tbMips.sv ====
`timescale 1ns/10ps

module tbMips;

    localparam int progLen    = 300;
    localparam int romWords   = 1024;
    localparam int ramWords   = 256;
    localparam int cycleLimit = 3 * progLen + 50;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  dest;
        logic [31:0] value;
    } regWrite_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } store_t;

    logic        clk;
    logic        arstN;
    logic [31:0] instAddr;
    logic [31:0] instRdata;
    logic [31:0] dataAddr;
    logic [31:0] dataWdata;
    logic        dataWe;
    logic [31:0] dataRdata;
    logic        grfWe;
    logic [4:0]  grfAddr;
    logic [31:0] grfWdata;
    logic [31:0] wbPc;

    logic [31:0] instRom [romWords];
    logic [31:0] dataRam [ramWords];
    logic [31:0] refMem  [ramWords];      // Model copy of the data RAM
    regWrite_t   expWrites[$];
    store_t      expStores[$];
    int          writesSeen = 0;
    int          storesSeen = 0;
    int          cycles     = 0;

    mipsCore mipsCore_inst (
        .clk(clk), .arstN(arstN),
        .instAddr(instAddr), .instRdata(instRdata),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe), .dataRdata(dataRdata),
        .grfWe(grfWe), .grfAddr(grfAddr), .grfWdata(grfWdata), .wbPc(wbPc)
    );

    assign instRdata = instRom[instAddr[11:2]];   // Program sits at resetPc
    assign dataRdata = dataRam[dataAddr[9:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dataRam[dataAddr[9:2]] <= dataWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic failRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Strobes are compared mid-cycle against the next model event
    always @(negedge clk) begin
        if (grfWe) begin
            if (writesSeen >= expWrites.size()) begin
                failRun($sformatf("unexpected register write at %0t ns", $time));
            end else begin
                checkValue("wbPc", wbPc, expWrites[writesSeen].pc);
                checkValue("grfAddr", 32'(grfAddr), 32'(expWrites[writesSeen].dest));
                checkValue("grfWdata", grfWdata, expWrites[writesSeen].value);
                writesSeen++;
            end
        end
        if (dataWe) begin
            if (storesSeen >= expStores.size()) begin
                failRun($sformatf("unexpected store at %0t ns", $time));
            end else begin
                checkValue("dataAddr", dataAddr, expStores[storesSeen].addr);
                checkValue("dataWdata", dataWdata, expStores[storesSeen].data);
                storesSeen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            failRun($sformatf("timeout after %0d cycles, %0d of %0d writes and %0d of %0d stores",
                              cycles, writesSeen, expWrites.size(), storesSeen, expStores.size()));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Program generation

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        rType = {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        iType = {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] srcReg();
        int r;
        r = int'($urandom_range(8, 0));
        srcReg = (r == 8) ? 5'd31 : 5'(r);        // Occasionally read the link register
    endfunction

    function automatic logic [4:0] dstReg();
        dstReg = 5'($urandom_range(7, 0));       // Register 0 checks the write rule
    endfunction

    function automatic logic [15:0] wordOffset();
        wordOffset = 16'($urandom_range(255, 0) << 2);
    endfunction

    task automatic genProgram();
        int          kind;
        int          target;
        logic [4:0]  rs;
        logic [31:0] jalAddr;
        logic        inSlot;
        inSlot = 1'b0;
        for (int i = 0; i < romWords; i++) begin
            instRom[i] = 32'h0;
        end
        for (int i = 0; i < progLen; i++) begin
            kind = int'($urandom_range(11, 0));
            if ((inSlot || i > progLen - 3) && (kind == 8 || kind == 9)) begin
                kind = kind - 8;                  // No jumps in a delay slot or at the end
            end
            target = int'($urandom_range(progLen, i + 2));
            rs     = srcReg();
            case (kind)
                0: instRom[i] = rType(rs, srcReg(), dstReg(), mipsPkg::fnAddu);
                1: instRom[i] = rType(rs, srcReg(), dstReg(), mipsPkg::fnSubu);
                2: instRom[i] = rType(rs, srcReg(), dstReg(), mipsPkg::fnOr);
                3: instRom[i] = rType(rs, srcReg(), dstReg(), mipsPkg::fnSlt);
                4: instRom[i] = iType(mipsPkg::opOri, rs, dstReg(), 16'($urandom));
                5: instRom[i] = iType(mipsPkg::opLui, 5'd0, dstReg(), 16'($urandom));
                6, 11: instRom[i] = iType(mipsPkg::opLw, 5'd0, dstReg(), wordOffset());
                7: instRom[i] = iType(mipsPkg::opSw, 5'd0, rs, wordOffset());
                8: instRom[i] = iType(mipsPkg::opBeq, rs,
                                      ($urandom_range(1, 0) == 1) ? rs : srcReg(),
                                      16'(target - i - 1));
                9: begin
                    jalAddr    = mipsPkg::resetPc + 32'(4 * target);
                    instRom[i] = {6'(mipsPkg::opJal), jalAddr[27:2]};
                end
                default: instRom[i] = 32'h0;
            endcase
            inSlot = (kind == 8 || kind == 9);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // ISA reference model, one instruction at a time

    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] after;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        pc  = mipsPkg::resetPc;
        npc = pc + 32'd4;
        while (pc < mipsPkg::resetPc + 32'(4 * progLen)) begin
            ins    = instRom[pc[11:2]];
            a      = regs[ins[25:21]];
            b      = regs[ins[20:16]];
            simm   = {{16{ins[15]}}, ins[15:0]};
            addr   = a + simm;
            after  = npc + 32'd4;
            dest   = ins[20:16];
            wr     = 1'b1;
            result = '0;
            case (ins[31:26])
                6'h00: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        6'h21:   result = a + b;
                        6'h23:   result = a - b;
                        6'h25:   result = a | b;
                        6'h2a:   result = {31'b0, $signed(a) < $signed(b)};
                        default: wr = 1'b0;       // All-zero word is nop
                    endcase
                end
                6'h0d: result = a | {16'b0, ins[15:0]};
                6'h0f: result = {ins[15:0], 16'b0};
                6'h23: result = refMem[addr[9:2]];
                6'h2b: begin
                    wr                = 1'b0;
                    refMem[addr[9:2]] = b;
                    expStores.push_back(store_t'{addr: addr, data: b});
                end
                6'h04: begin
                    wr = 1'b0;
                    if (a == b) after = npc + {simm[29:0], 2'b00};  // Relative to delay slot
                end
                6'h03: begin
                    dest   = 5'd31;
                    result = pc + 32'd8;
                    after  = {npc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                regs[dest] = result;
                expWrites.push_back(regWrite_t'{pc: pc, dest: dest, value: result});
            end
            pc  = npc;
            npc = after;
        end
    endtask

    function automatic logic [31:0] fillWord(input int index);
        logic [15:0] addr;
        addr     = 16'(index * 4);
        fillWord = {addr ^ 16'h5a5a, ~addr};
    endfunction

    initial begin
        arstN = 1'b0;
        void'($urandom(32'h391a7172));
        for (int i = 0; i < ramWords; i++) begin
            dataRam[i] <= fillWord(i);
            refMem[i]  = fillWord(i);
        end
        genProgram();
        runModel();
        repeat (2) @(posedge clk);
        #5 arstN = 1'b1;
        while (writesSeen < expWrites.size() || storesSeen < expStores.size()) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);                // Catch strobes beyond the model
        $display("%0d register writes and %0d stores matched", writesSeen, storesSeen);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== sources.f ====
mipsPkg.sv
fetchUnit.sv
regFile.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memWriteback.sv
mipsCore.sv
mipsCore_properties.sv
tbMips.sv

// ==== Makefile ====
SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: obj_dir/VtbMips

obj_dir/VtbMips: sources.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tbMips -f sources.f

run: obj_dir/VtbMips
	./obj_dir/VtbMips

clean:
	rm -rf obj_dir
